// ==== hdl/alu_decoder.sv ====
`timescale 1ns/1ps

module alu_decoder (
  input  alu_pkg::inst_t    i_inst,
  output alu_pkg::alu_op_t  o_op,
  output alu_pkg::imm_sel_t o_imm
);

  import alu_pkg::*;

  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;  // SUB and SRA.

  logic [6:0] w_opcode;
  logic [2:0] w_funct3;
  logic [6:0] w_funct7;

  assign w_opcode = i_inst[6:0];
  assign w_funct3 = i_inst[14:12];
  assign w_funct7 = i_inst[31:25];

  always_comb begin
    o_op  = OP_NONE;
    o_imm = IMM_NONE;
    case (w_opcode)
      OPC_LUI: begin
        o_op  = OP_LUI;
        o_imm = IMM_U;
      end
      OPC_AUIPC: begin
        o_op  = OP_AUIPC;
        o_imm = IMM_U;
      end
      OPC_OP_IMM: begin
        o_imm = IMM_I;
        case (w_funct3)
          3'b000: o_op = OP_ADD;
          3'b010: o_op = OP_SLT;
          3'b011: o_op = OP_SLTU;
          3'b100: o_op = OP_XOR;
          3'b110: o_op = OP_OR;
          3'b111: o_op = OP_AND;
          3'b001: begin
            o_imm = IMM_SH;
            if (w_funct7 == F7_BASE) o_op = OP_SLL;
          end
          default: begin  // 3'b101 is a logical or arithmetic right shift.
            o_imm = IMM_SH;
            if (w_funct7 == F7_BASE) o_op = OP_SRL;
            else if (w_funct7 == F7_ALT) o_op = OP_SRA;
          end
        endcase
      end
      OPC_OP: begin
        if (w_funct7 == F7_BASE) begin
          case (w_funct3)
            3'b000: o_op = OP_ADD;
            3'b001: o_op = OP_SLL;
            3'b010: o_op = OP_SLT;
            3'b011: o_op = OP_SLTU;
            3'b100: o_op = OP_XOR;
            3'b101: o_op = OP_SRL;
            3'b110: o_op = OP_OR;
            default: o_op = OP_AND;
          endcase
        end else if (w_funct7 == F7_ALT) begin
          if (w_funct3 == 3'b000) o_op = OP_SUB;
          else if (w_funct3 == 3'b101) o_op = OP_SRA;
        end
      end
      default: ;  // Not an ALU instruction.
    endcase
  end

endmodule

// ==== hdl/alu_pipe.sv ====
`timescale 1ns/1ps

module alu_pipe #(
  parameter int RV_ENTRY_SIZE = 8
) (
  input  logic                     i_clk,
  input  logic                     i_reset_n,
  input  alu_pkg::issue_t          i_issue,
  input  logic [RV_ENTRY_SIZE-1:0] i_index,
  output alu_pkg::rd_req_t         o_rd_req [2],
  input  alu_pkg::xlen_t           i_rd_data[2],
  input  alu_pkg::phy_wr_t         i_fwd_wr [alu_pkg::FWD_BUS_SIZE],
  output alu_pkg::early_wr_t       o_early_wr,
  output alu_pkg::phy_wr_t         o_phy_wr,
  output logic                     o_done_valid,
  output logic [RV_ENTRY_SIZE-1:0] o_done_index
);

  import alu_pkg::*;

  localparam int SHAMT_W = $clog2(XLEN);

  alu_op_t  w_ex0_op;
  imm_sel_t w_ex0_imm;

  logic                     r_ex1_valid;
  issue_t                   r_ex1_issue;
  logic [RV_ENTRY_SIZE-1:0] r_ex1_index;
  alu_op_t                  r_ex1_op;
  imm_sel_t                 r_ex1_imm;

  logic                     r_ex2_valid;
  issue_t                   r_ex2_issue;
  logic [RV_ENTRY_SIZE-1:0] r_ex2_index;
  alu_op_t                  r_ex2_op;
  imm_sel_t                 r_ex2_imm;
  xlen_t                    r_ex2_rs1_data;
  xlen_t                    r_ex2_rs2_data;

  logic [FWD_BUS_SIZE-1:0]  w_ex2_rs1_hit;
  logic [FWD_BUS_SIZE-1:0]  w_ex2_rs2_hit;
  xlen_t                    w_ex2_rs1_fwd;
  xlen_t                    w_ex2_rs2_fwd;
  xlen_t                    w_ex2_op1;
  xlen_t                    w_ex2_op2;
  xlen_t                    w_ex2_result;

  logic                     r_ex3_valid;
  issue_t                   r_ex3_issue;
  logic [RV_ENTRY_SIZE-1:0] r_ex3_index;
  xlen_t                    r_ex3_result;

  // ====================================================================
  // EX0 decode, EX1 register read
  // ====================================================================
  alu_decoder u_decoder (
    .i_inst(i_issue.inst),
    .o_op  (w_ex0_op),
    .o_imm (w_ex0_imm)
  );

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex1_valid <= 1'b0;
      r_ex2_valid <= 1'b0;
      r_ex3_valid <= 1'b0;
    end else begin
      r_ex1_valid <= i_issue.valid;
      r_ex2_valid <= r_ex1_valid;
      r_ex3_valid <= r_ex2_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    r_ex1_issue <= i_issue;
    r_ex1_index <= i_index;
    r_ex1_op    <= w_ex0_op;
    r_ex1_imm   <= w_ex0_imm;
  end

  assign o_rd_req[0].valid = r_ex1_valid & r_ex1_issue.rs1_valid;
  assign o_rd_req[0].rnid  = r_ex1_issue.rs1_rnid;
  assign o_rd_req[1].valid = r_ex1_valid & r_ex1_issue.rs2_valid;
  assign o_rd_req[1].rnid  = r_ex1_issue.rs2_rnid;

  assign o_early_wr.valid   = r_ex1_valid & r_ex1_issue.rd_valid;
  assign o_early_wr.rd_rnid = r_ex1_issue.rd_rnid;

  always_ff @(posedge i_clk) begin
    r_ex2_issue    <= r_ex1_issue;
    r_ex2_index    <= r_ex1_index;
    r_ex2_op       <= r_ex1_op;
    r_ex2_imm      <= r_ex1_imm;
    r_ex2_rs1_data <= i_rd_data[0];
    case (r_ex1_imm)
      IMM_I:   r_ex2_rs2_data <= {{(XLEN-12){r_ex1_issue.inst[31]}}, r_ex1_issue.inst[31:20]};
      IMM_SH:  r_ex2_rs2_data <= {{(XLEN-SHAMT_W){1'b0}}, r_ex1_issue.inst[20 +: SHAMT_W]};
      IMM_U:   r_ex2_rs2_data <= {r_ex1_issue.inst[31:12], 12'h000};
      default: r_ex2_rs2_data <= i_rd_data[1];
    endcase
  end

  // ====================================================================
  // EX2 forwarding and execute
  // ====================================================================
  for (genvar b = 0; b < FWD_BUS_SIZE; b++) begin : g_fwd_match
    assign w_ex2_rs1_hit[b] = r_ex2_issue.rs1_valid & i_fwd_wr[b].valid &
                              (i_fwd_wr[b].rd_rnid == r_ex2_issue.rs1_rnid) &
                              (r_ex2_issue.rs1_rnid != '0);
    assign w_ex2_rs2_hit[b] = r_ex2_issue.rs2_valid & (r_ex2_imm == IMM_NONE) &
                              i_fwd_wr[b].valid &
                              (i_fwd_wr[b].rd_rnid == r_ex2_issue.rs2_rnid) &
                              (r_ex2_issue.rs2_rnid != '0);
  end

  always_comb begin
    w_ex2_rs1_fwd = '0;
    w_ex2_rs2_fwd = '0;
    for (int b = 0; b < FWD_BUS_SIZE; b++) begin
      w_ex2_rs1_fwd = w_ex2_rs1_fwd | ({XLEN{w_ex2_rs1_hit[b]}} & i_fwd_wr[b].rd_data);
      w_ex2_rs2_fwd = w_ex2_rs2_fwd | ({XLEN{w_ex2_rs2_hit[b]}} & i_fwd_wr[b].rd_data);
    end
  end

  assign w_ex2_op1 = |w_ex2_rs1_hit ? w_ex2_rs1_fwd : r_ex2_rs1_data;
  assign w_ex2_op2 = |w_ex2_rs2_hit ? w_ex2_rs2_fwd : r_ex2_rs2_data;

  always_comb begin
    case (r_ex2_op)
      OP_LUI:   w_ex2_result = w_ex2_op2;  // U immediate already in place.
      OP_AUIPC: w_ex2_result = r_ex2_issue.pc + w_ex2_op2;
      OP_ADD:   w_ex2_result = w_ex2_op1 + w_ex2_op2;
      OP_SUB:   w_ex2_result = w_ex2_op1 - w_ex2_op2;
      OP_XOR:   w_ex2_result = w_ex2_op1 ^ w_ex2_op2;
      OP_OR:    w_ex2_result = w_ex2_op1 | w_ex2_op2;
      OP_AND:   w_ex2_result = w_ex2_op1 & w_ex2_op2;
      OP_SLL:   w_ex2_result = w_ex2_op1 << w_ex2_op2[SHAMT_W-1:0];
      OP_SRL:   w_ex2_result = w_ex2_op1 >> w_ex2_op2[SHAMT_W-1:0];
      OP_SRA:   w_ex2_result = xlen_t'($signed(w_ex2_op1) >>> w_ex2_op2[SHAMT_W-1:0]);
      OP_SLT:   w_ex2_result = {{(XLEN-1){1'b0}}, $signed(w_ex2_op1) < $signed(w_ex2_op2)};
      OP_SLTU:  w_ex2_result = {{(XLEN-1){1'b0}}, w_ex2_op1 < w_ex2_op2};
      default:  w_ex2_result = '0;
    endcase
  end

  // ====================================================================
  // EX3 writeback and done
  // ====================================================================
  always_ff @(posedge i_clk) begin
    r_ex3_issue  <= r_ex2_issue;
    r_ex3_index  <= r_ex2_index;
    r_ex3_result <= w_ex2_result;
  end

  assign o_phy_wr.valid   = r_ex3_valid & r_ex3_issue.rd_valid;
  assign o_phy_wr.rd_rnid = r_ex3_issue.rd_rnid;
  assign o_phy_wr.rd_data = r_ex3_result;

  assign o_done_valid = r_ex3_valid;
  assign o_done_index = r_ex3_index;

  a_fwd_onehot: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    r_ex2_valid |-> ($onehot0(w_ex2_rs1_hit) && $onehot0(w_ex2_rs2_hit)))
    else $error("alu_pipe: more than one forwarding bus matched");

  a_done_onehot: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_done_valid |-> $onehot(o_done_index))
    else $error("alu_pipe: done index is not one-hot");

  a_wr_with_done: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_phy_wr.valid |-> o_done_valid)
    else $error("alu_pipe: writeback without done");

endmodule

// ==== hdl/alu_pkg.sv ====
package alu_pkg;

  // ====================================================================
  // Widths
  // ====================================================================
  localparam int XLEN         = 32;
  localparam int RNID_W       = 6;
  localparam int FWD_BUS_SIZE = 2;  // Bus 0 is the ALU EX3, bus 1 the external writer.

  typedef logic [XLEN-1:0]   xlen_t;
  typedef logic [31:0]       inst_t;
  typedef logic [RNID_W-1:0] rnid_t;  // Tag 0 maps to x0.

  // ====================================================================
  // Pipe records
  // ====================================================================
  typedef struct packed {
    logic  valid;
    inst_t inst;
    xlen_t pc;
    logic  rs1_valid;
    rnid_t rs1_rnid;
    logic  rs2_valid;
    rnid_t rs2_rnid;
    logic  rd_valid;
    rnid_t rd_rnid;
  } issue_t;

  typedef struct packed {
    logic  valid;
    rnid_t rd_rnid;
    xlen_t rd_data;
  } phy_wr_t;

  typedef struct packed {
    logic  valid;
    rnid_t rd_rnid;
  } early_wr_t;

  typedef struct packed {
    logic  valid;
    rnid_t rnid;
  } rd_req_t;

  // ====================================================================
  // Decode results
  // ====================================================================
  typedef enum logic [3:0] {
    OP_NONE,
    OP_LUI,
    OP_AUIPC,
    OP_ADD,
    OP_SUB,
    OP_XOR,
    OP_OR,
    OP_AND,
    OP_SLL,
    OP_SRL,
    OP_SRA,
    OP_SLT,
    OP_SLTU
  } alu_op_t;

  typedef enum logic [1:0] {
    IMM_NONE,  // Operand 2 from rs2.
    IMM_I,
    IMM_SH,
    IMM_U
  } imm_sel_t;

endpackage

// ==== hdl/alu_subsystem.sv ====
`timescale 1ns/1ps

module alu_subsystem #(
  parameter int RV_ENTRY_SIZE = 8,
  parameter int NUM_PHY_REGS  = 64
) (
  input  logic                     i_clk,
  input  logic                     i_reset_n,
  input  alu_pkg::issue_t          i_issue,
  input  logic [RV_ENTRY_SIZE-1:0] i_index,
  input  alu_pkg::phy_wr_t         i_ext_wr,
  output alu_pkg::early_wr_t       o_early_wr,
  output alu_pkg::phy_wr_t         o_phy_wr,
  output logic                     o_done_valid,
  output logic [RV_ENTRY_SIZE-1:0] o_done_index
);

  import alu_pkg::*;

  rd_req_t w_rd_req [2];
  xlen_t   w_rd_data[2];
  phy_wr_t w_pipe_wr;
  phy_wr_t w_wb_bus [FWD_BUS_SIZE];

  assign w_wb_bus[0] = w_pipe_wr;  // ALU result.
  assign w_wb_bus[1] = i_ext_wr;
  assign o_phy_wr    = w_pipe_wr;

  alu_pipe #(
    .RV_ENTRY_SIZE(RV_ENTRY_SIZE)
  ) u_alu_pipe (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_issue     (i_issue),
    .i_index     (i_index),
    .o_rd_req    (w_rd_req),
    .i_rd_data   (w_rd_data),
    .i_fwd_wr    (w_wb_bus),
    .o_early_wr  (o_early_wr),
    .o_phy_wr    (w_pipe_wr),
    .o_done_valid(o_done_valid),
    .o_done_index(o_done_index)
  );

  phys_regfile #(
    .NUM_PHY_REGS(NUM_PHY_REGS)
  ) u_phys_regfile (
    .i_clk    (i_clk),
    .i_reset_n(i_reset_n),
    .i_rd_req (w_rd_req),
    .o_rd_data(w_rd_data),
    .i_wr     (w_wb_bus)
  );

endmodule

// ==== hdl/phys_regfile.sv ====
`timescale 1ns/1ps

module phys_regfile #(
  parameter int NUM_PHY_REGS = 64
) (
  input  logic             i_clk,
  input  logic             i_reset_n,
  input  alu_pkg::rd_req_t i_rd_req [2],
  output alu_pkg::xlen_t   o_rd_data[2],
  input  alu_pkg::phy_wr_t i_wr     [alu_pkg::FWD_BUS_SIZE]
);

  import alu_pkg::*;

  xlen_t r_regs[NUM_PHY_REGS];
  logic  w_wr_collide;

  // The higher bus wins as in the write below.
  always_comb begin
    for (int p = 0; p < 2; p++) begin
      o_rd_data[p] = r_regs[i_rd_req[p].rnid];
      for (int b = 0; b < FWD_BUS_SIZE; b++) begin
        if (i_wr[b].valid && (i_wr[b].rd_rnid == i_rd_req[p].rnid)) begin
          o_rd_data[p] = i_wr[b].rd_data;  // Write-through.
        end
      end
      if (!i_rd_req[p].valid || (i_rd_req[p].rnid == '0)) o_rd_data[p] = '0;
    end
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 0; i < NUM_PHY_REGS; i++) r_regs[i] <= '0;
    end else begin
      for (int b = 0; b < FWD_BUS_SIZE; b++) begin
        if (i_wr[b].valid && (i_wr[b].rd_rnid != '0)) begin
          r_regs[i_wr[b].rd_rnid] <= i_wr[b].rd_data;
        end
      end
    end
  end

  // Two buses on one live tag in the same cycle.
  always_comb begin
    w_wr_collide = 1'b0;
    for (int a = 0; a < FWD_BUS_SIZE; a++) begin
      for (int b = a + 1; b < FWD_BUS_SIZE; b++) begin
        if (i_wr[a].valid && i_wr[b].valid && (i_wr[a].rd_rnid == i_wr[b].rd_rnid) &&
            (i_wr[a].rd_rnid != '0)) begin
          w_wr_collide = 1'b1;
        end
      end
    end
  end

  a_no_wr_collide: assert property (@(posedge i_clk) disable iff (!i_reset_n) !w_wr_collide)
    else $error("phys_regfile: two writeback buses hit one tag");

endmodule

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module alu_tb \
  --Mdir obj_dir -o alu_sim
./obj_dir/alu_sim | tee sim.log

if grep -qx "all tests passed" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

// ==== verif/alu_tb.sv ====
`timescale 1ns/1ps

module alu_tb;

  import alu_pkg::*;

  localparam int ENTRIES  = 8;
  localparam int NUM_REGS = 64;

  // Cycles per test with reset counted in the first.
  localparam int LEN_RESET   = 6 + 2 + 63 + 4;
  localparam int LEN_OPS     = 2 * 21 * 4;
  localparam int LEN_CHAIN   = 8 * 7;
  localparam int LEN_EXT     = 8 * 5;
  localparam int LEN_X0      = 6 * 7;
  localparam int LEN_WAKE    = 12 + 4;
  localparam int CYCLE_LIMIT =
    (LEN_RESET + LEN_OPS + LEN_CHAIN + LEN_EXT + LEN_X0 + LEN_WAKE) * 3 / 2 + 50;

  logic               clk;
  logic               reset_n;
  issue_t             issue_in;
  logic [ENTRIES-1:0] index_in;
  phy_wr_t            ext_wr_in;
  early_wr_t          early_wr_out;
  phy_wr_t            phy_wr_out;
  logic               done_valid;
  logic [ENTRIES-1:0] done_index;

  // Entry k of the delay line holds the instruction k edges past issue.
  issue_t             dl_issue[4];
  logic [ENTRIES-1:0] dl_index[4];
  xlen_t              dl_res  [4];
  xlen_t              shadow  [NUM_REGS];

  logic [31:0] lfsr_state;
  string       cur_test;
  int          err_count = 0;
  int          cycle_cnt = 0;
  int          test_start_err;
  int          n_tests;
  int          n_failed;

  early_wr_t        exp_early;
  phy_wr_t          exp_wr;
  logic [ENTRIES:0] exp_done;
  logic [ENTRIES:0] act_done;

  tb_clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(4)) u_clock_gen (
    .o_clk    (clk),
    .o_reset_n(reset_n)
  );

  alu_subsystem #(
    .RV_ENTRY_SIZE(ENTRIES),
    .NUM_PHY_REGS (NUM_REGS)
  ) dut0 (
    .i_clk       (clk),
    .i_reset_n   (reset_n),
    .i_issue     (issue_in),
    .i_index     (index_in),
    .i_ext_wr    (ext_wr_in),
    .o_early_wr  (early_wr_out),
    .o_phy_wr    (phy_wr_out),
    .o_done_valid(done_valid),
    .o_done_index(done_index)
  );

  // ====================================================================
  // Reference model
  // ====================================================================
  // Taps x^32 + x^22 + x^2 + x + 1 stepped once per bit.
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      v          = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic xlen_t ref_alu(inst_t inst, xlen_t pc, xlen_t a, xlen_t b);
    xlen_t src2;
    logic  alt;
    src2 = (inst[6:0] == 7'h33) ? b : {{20{inst[31]}}, inst[31:20]};
    alt  = inst[30];
    if (inst[6:0] == 7'h37) return {inst[31:12], 12'h000};
    if (inst[6:0] == 7'h17) return pc + {inst[31:12], 12'h000};
    if (inst[6:0] != 7'h13 && inst[6:0] != 7'h33) return '0;
    case (inst[14:12])
      3'd0: return (alt && inst[6:0] == 7'h33) ? a - src2 : a + src2;
      3'd1: return a << src2[4:0];
      3'd2: return ($signed(a) < $signed(src2)) ? 32'd1 : 32'd0;
      3'd3: return (a < src2) ? 32'd1 : 32'd0;
      3'd4: return a ^ src2;
      3'd5: return alt ? xlen_t'($signed(a) >>> src2[4:0]) : a >> src2[4:0];
      3'd6: return a | src2;
      default: return a & src2;
    endcase
  endfunction

  // Value of a tag as seen by the instruction now in EX2.
  function automatic xlen_t newest_value(rnid_t tag);
    xlen_t v;
    v = shadow[tag];
    if (dl_issue[3].valid && dl_issue[3].rd_valid && dl_issue[3].rd_rnid == tag) v = dl_res[3];
    if (ext_wr_in.valid && ext_wr_in.rd_rnid == tag) v = ext_wr_in.rd_data;
    if (tag == '0) v = '0;
    return v;
  endfunction

  // ====================================================================
  // Stimulus helpers
  // ====================================================================
  // Forms 0-1 U type, 2-11 register, 12-20 immediate.
  function automatic inst_t make_inst(int form);
    logic [19:0] u;
    logic [11:0] imm;
    logic [2:0]  f3;
    inst_t       inst;
    u   = 20'(take_bits(20));
    imm = 12'(take_bits(12));
    f3  = 3'(form - 12);
    if (form < 2) inst = {u, 5'd3, (form == 0) ? 7'h37 : 7'h17};
    else if (form < 10) inst = {7'h00, 5'd2, 5'd1, 3'(form - 2), 5'd3, 7'h33};
    else if (form == 10) inst = {7'h20, 5'd2, 5'd1, 3'd0, 5'd3, 7'h33};
    else if (form == 11) inst = {7'h20, 5'd2, 5'd1, 3'd5, 5'd3, 7'h33};
    else if (form < 20 && (f3 == 3'd1 || f3 == 3'd5))
      inst = {7'h00, imm[4:0], 5'd1, f3, 5'd3, 7'h13};
    else if (form < 20) inst = {imm, 5'd1, f3, 5'd3, 7'h13};
    else inst = {7'h20, imm[4:0], 5'd1, 3'd5, 5'd3, 7'h13};
    return inst;
  endfunction

  function automatic int rand_r_form();
    return 2 + int'(take_bits(4)) % 10;
  endfunction

  function automatic rnid_t rand_tag();
    rnid_t t;
    do t = rnid_t'(take_bits(6)); while (t == '0);
    return t;
  endfunction

  function automatic logic [ENTRIES-1:0] onehot_index();
    return {{(ENTRIES-1){1'b0}}, 1'b1} << take_bits($clog2(ENTRIES));
  endfunction

  function automatic issue_t make_issue(inst_t inst, rnid_t rs1, rnid_t rs2, rnid_t rd,
                                        logic rd_valid);
    issue_t iss;
    iss           = '0;
    iss.valid     = 1'b1;
    iss.inst      = inst;
    iss.pc        = take_bits(30) << 2;
    iss.rs1_valid = (inst[6:0] == 7'h13) || (inst[6:0] == 7'h33);
    iss.rs1_rnid  = rs1;
    iss.rs2_valid = (inst[6:0] == 7'h33);
    iss.rs2_rnid  = rs2;
    iss.rd_valid  = rd_valid;
    iss.rd_rnid   = rd;
    return iss;
  endfunction

  function automatic phy_wr_t ext_write(rnid_t tag, xlen_t data);
    return '{valid: 1'b1, rd_rnid: tag, rd_data: data};
  endfunction

  // One clock from falling edge to falling edge.
  task automatic run_cycle(input issue_t iss, input logic [ENTRIES-1:0] idx, input phy_wr_t ew);
    xlen_t a;
    xlen_t b;
    issue_in    = iss;
    index_in    = idx;
    ext_wr_in   = ew;
    dl_issue[0] = iss;
    dl_index[0] = idx;
    if (dl_issue[2].valid) begin
      a = dl_issue[2].rs1_valid ? newest_value(dl_issue[2].rs1_rnid) : '0;
      b = dl_issue[2].rs2_valid ? newest_value(dl_issue[2].rs2_rnid) : '0;
      dl_res[2] = ref_alu(dl_issue[2].inst, dl_issue[2].pc, a, b);
    end
    @(posedge clk);
    if (exp_wr.valid && exp_wr.rd_rnid != '0) shadow[exp_wr.rd_rnid] = exp_wr.rd_data;
    if (ew.valid && ew.rd_rnid != '0) shadow[ew.rd_rnid] = ew.rd_data;
    for (int k = 3; k > 0; k--) begin
      dl_issue[k] = dl_issue[k-1];
      dl_index[k] = dl_index[k-1];
      dl_res[k]   = dl_res[k-1];
    end
    dl_issue[0] = '0;
    @(negedge clk);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) run_cycle('0, '0, '0);
  endtask

  task automatic begin_test(input string name);
    cur_test       = name;
    test_start_err = err_count;
  endtask

  task automatic end_test();
    n_tests++;
    if (err_count == test_start_err) begin
      $display("test %s: ok", cur_test);
    end else begin
      n_failed++;
      $display("test %s: %0d errors", cur_test, err_count - test_start_err);
    end
  endtask

  // ====================================================================
  // Checks
  // ====================================================================
  assign exp_early.valid   = dl_issue[1].valid & dl_issue[1].rd_valid;
  assign exp_early.rd_rnid = dl_issue[1].rd_rnid;
  assign exp_wr.valid      = dl_issue[3].valid & dl_issue[3].rd_valid;
  assign exp_wr.rd_rnid    = dl_issue[3].rd_rnid;
  assign exp_wr.rd_data    = dl_res[3];
  assign exp_done          = {dl_issue[3].valid, dl_index[3]};
  assign act_done          = {done_valid, done_index};

  a_quiet_in_reset: assert property (@(posedge clk)
    !reset_n |-> !(phy_wr_out.valid || early_wr_out.valid || done_valid))
    else begin
      err_count++;
      $display("test %s: a valid output rose while reset was held", cur_test);
    end

  a_early_wr: assert property (@(posedge clk) disable iff (!reset_n)
    (early_wr_out.valid == exp_early.valid) && (!exp_early.valid || early_wr_out == exp_early))
    else begin
      err_count++;
      $display("mismatch %s early_wr: expected %h actual %h",
               cur_test, $sampled(exp_early), $sampled(early_wr_out));
    end

  a_done: assert property (@(posedge clk) disable iff (!reset_n)
    (act_done[ENTRIES] == exp_done[ENTRIES]) && (!exp_done[ENTRIES] || act_done == exp_done))
    else begin
      err_count++;
      $display("mismatch %s done: expected %h actual %h",
               cur_test, $sampled(exp_done), $sampled(act_done));
    end

  a_phy_wr: assert property (@(posedge clk) disable iff (!reset_n)
    (phy_wr_out.valid == exp_wr.valid) && (!exp_wr.valid || phy_wr_out == exp_wr))
    else begin
      err_count++;
      $display("mismatch %s phy_wr: expected %h actual %h",
               cur_test, $sampled(exp_wr), $sampled(phy_wr_out));
    end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("timeout: run went past %0d cycles", CYCLE_LIMIT);
      $display("tests failed");
      $finish;
    end
  end

  // ====================================================================
  // Tests
  // ====================================================================
  initial begin
    rnid_t ta;
    rnid_t tb_tag;
    issue_in   = '0;
    index_in   = '0;
    ext_wr_in  = '0;
    lfsr_state = 32'hf57d_2629;
    n_tests    = 0;
    n_failed   = 0;
    for (int k = 0; k < 4; k++) begin
      dl_issue[k] = '0;
      dl_index[k] = '0;
      dl_res[k]   = '0;
    end
    for (int t = 0; t < NUM_REGS; t++) shadow[t] = '0;
    begin_test("reset_load");
    @(posedge reset_n);
    @(negedge clk);
    idle_cycles(2);
    for (int t = 1; t < NUM_REGS; t++) run_cycle('0, '0, ext_write(rnid_t'(t), take_bits(32)));
    idle_cycles(4);
    end_test();

    begin_test("alu_ops");
    for (int r = 0; r < 2; r++) begin
      for (int f = 0; f < 21; f++) begin
        run_cycle(make_issue(make_inst(f), rand_tag(), rand_tag(), rand_tag(), 1'b1),
                  onehot_index(), '0);
        idle_cycles(3);
      end
    end
    end_test();

    begin_test("fwd_chain");
    for (int i = 0; i < 8; i++) begin
      ta     = rand_tag();
      tb_tag = rand_tag();
      run_cycle(make_issue(make_inst(rand_r_form()), rand_tag(), rand_tag(), ta, 1'b1),
                onehot_index(), '0);
      run_cycle(make_issue(make_inst(rand_r_form()), ta, rand_tag(), tb_tag, 1'b1),
                onehot_index(), '0);
      run_cycle(make_issue(make_inst(rand_r_form()), tb_tag, ta, rand_tag(), 1'b1),
                onehot_index(), '0);  // Distance 1 on rs1, 2 on rs2.
      idle_cycles(4);
    end
    end_test();

    begin_test("ext_bypass");
    for (int i = 0; i < 8; i++) begin
      ta     = rand_tag();
      tb_tag = rand_tag();
      run_cycle(make_issue(make_inst(rand_r_form()), ta, tb_tag, rand_tag(), 1'b1),
                onehot_index(), '0);
      run_cycle('0, '0, ext_write(ta, take_bits(32)));      // Consumer in EX1.
      run_cycle('0, '0, ext_write(tb_tag, take_bits(32)));  // Consumer in EX2.
      idle_cycles(2);
    end
    end_test();

    begin_test("x0_source");
    for (int i = 0; i < 6; i++) begin
      run_cycle(make_issue(make_inst(rand_r_form()), rand_tag(), rand_tag(), '0, 1'b1),
                onehot_index(), '0);
      run_cycle(make_issue(make_inst(rand_r_form()), '0, '0, rand_tag(), 1'b1),
                onehot_index(), '0);
      run_cycle(make_issue(make_inst(12 + int'(take_bits(3))), '0, rand_tag(), rand_tag(), 1'b1),
                onehot_index(), ext_write('0, take_bits(32)));
      idle_cycles(1);
      run_cycle('0, '0, ext_write('0, take_bits(32)));
      idle_cycles(2);
    end
    end_test();

    begin_test("wakeup_done");
    for (int i = 0; i < 12; i++) begin
      run_cycle(make_issue(make_inst(int'(take_bits(5)) % 21), rand_tag(), rand_tag(),
                           rand_tag(), 1'(take_bits(1))), onehot_index(), '0);
    end
    idle_cycles(4);
    end_test();

    $display("%0d tests run, %0d failed, %0d errors", n_tests, n_failed, err_count);
    if (err_count == 0 && n_failed == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 4
) (
  output logic o_clk,
  output logic o_reset_n
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD_NS / 2) o_clk = ~o_clk;
  end

  initial begin
    o_reset_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_clk);
    @(negedge o_clk);
    o_reset_n = 1'b1;  // Released away from the rising edge.
  end

endmodule

// ==== verilog.f ====
hdl/alu_pkg.sv
hdl/alu_decoder.sv
hdl/phys_regfile.sv
hdl/alu_pipe.sv
hdl/alu_subsystem.sv
verif/tb_clock_gen.sv
verif/alu_tb.sv
